// ==== verilog/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

	// bus widths
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// axi response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// controller state encoding
	localparam int         ST_W          = 3;
	localparam logic [2:0] ST_IDLE       = 3'd0;
	localparam logic [2:0] ST_READ_ADDR  = 3'd1;
	localparam logic [2:0] ST_READ_DATA  = 3'd2;
	localparam logic [2:0] ST_WRITE      = 3'd3;
	localparam logic [2:0] ST_WRITE_RESP = 3'd4;

	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		OP_LB   = 4'd1,
		OP_LBU  = 4'd2,
		OP_LH   = 4'd3,
		OP_LHU  = 4'd4,
		OP_LW   = 4'd5,
		OP_SB   = 4'd6,
		OP_SH   = 4'd7,
		OP_SW   = 4'd8
	} mem_op_t;

	// one bus word, lane view by byte or by halfword
	typedef union packed {
		logic [AXI_STRB_W-1:0][7:0]       bytes;
		logic [AXI_DATA_W/16-1:0][15:0]   halves;
	} mem_word_u;

endpackage

`default_nettype wire

// ==== verilog/mem_access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
	input  wire                                       axi_aclk_i,
	input  wire                                       axi_aresetn_i,

	input  wire                                       req_start_i,
	input  wire mem_access_pkg::mem_op_t              req_op_i,
	input  wire [mem_access_pkg::AXI_ADDR_W-1:0]      req_addr_i,
	input  wire [mem_access_pkg::AXI_DATA_W-1:0]      req_wdata_i,

	output logic [mem_access_pkg::AXI_ADDR_W-1:0]     axi_araddr_o,
	output logic                                      axi_arvalid_o,
	input  wire                                       axi_arready_i,
	input  wire                                       axi_rvalid_i,
	input  wire [1:0]                                 axi_rresp_i,
	output logic                                      axi_rready_o,

	output logic [mem_access_pkg::AXI_ADDR_W-1:0]     axi_awaddr_o,
	output logic                                      axi_awvalid_o,
	input  wire                                       axi_awready_i,
	output logic                                      axi_wvalid_o,
	input  wire                                       axi_wready_i,
	input  wire                                       axi_bvalid_i,
	input  wire [1:0]                                 axi_bresp_i,
	output logic                                      axi_bready_o,

	output mem_access_pkg::mem_op_t                   op_o,
	output logic [1:0]                                offset_o,
	output logic [mem_access_pkg::AXI_DATA_W-1:0]     store_data_o,
	output logic                                      capture_o,
	output logic                                      busy_o,
	output logic                                      store_done_o,
	output logic                                      err_o
);
	import mem_access_pkg::*;

	logic [ST_W-1:0]       state_r;
	logic [ST_W-1:0]       state_nxt;
	mem_op_t               op_r;
	logic [AXI_ADDR_W-1:0] addr_r;
	logic [AXI_DATA_W-1:0] data_r;
	logic                  aw_done_r;
	logic                  w_done_r;
	logic                  store_done_r;
	logic                  err_r;

	logic accept;
	logic is_load;
	logic aligned;
	logic ar_hs;
	logic r_hs;
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic aw_ok;
	logic w_ok;

	function automatic logic resp_err(input logic [1:0] resp);
		logic err;
		case (resp)
			RESP_OKAY:               err = 1'b0;
			RESP_SLVERR, RESP_DECERR: err = 1'b1;
			default:                 err = 1'b1; // exokay has no meaning on axi-lite
		endcase
		return err;
	endfunction

	assign busy_o = (state_r != ST_IDLE);
	assign accept = req_start_i && !busy_o; // strobes while busy are dropped

	// op decode and alignment check
	always_comb begin
		is_load = 1'b0;
		aligned = 1'b0;
		case (req_op_i)
			OP_LB, OP_LBU: begin
				is_load = 1'b1;
				aligned = 1'b1;
			end
			OP_LH, OP_LHU: begin
				is_load = 1'b1;
				aligned = !req_addr_i[0];
			end
			OP_LW: begin
				is_load = 1'b1;
				aligned = (req_addr_i[1:0] == 2'b00);
			end
			OP_SB: aligned = 1'b1;
			OP_SH: aligned = !req_addr_i[0];
			OP_SW: aligned = (req_addr_i[1:0] == 2'b00);
			default: aligned = 1'b0; // unknown op is refused
		endcase
	end

	assign axi_arvalid_o = (state_r == ST_READ_ADDR);
	assign axi_rready_o  = (state_r == ST_READ_DATA);
	assign axi_awvalid_o = (state_r == ST_WRITE) && !aw_done_r;
	assign axi_wvalid_o  = (state_r == ST_WRITE) && !w_done_r;
	assign axi_bready_o  = (state_r == ST_WRITE_RESP);

	assign ar_hs = axi_arvalid_o && axi_arready_i;
	assign r_hs  = axi_rready_o && axi_rvalid_i;
	assign aw_hs = axi_awvalid_o && axi_awready_i;
	assign w_hs  = axi_wvalid_o && axi_wready_i;
	assign b_hs  = axi_bready_o && axi_bvalid_i;

	assign aw_ok = aw_done_r || aw_hs;
	assign w_ok  = w_done_r || w_hs;

	always_comb begin
		state_nxt = state_r;
		case (state_r)
			ST_IDLE: begin
				if (accept && aligned)
					state_nxt = is_load ? ST_READ_ADDR : ST_WRITE;
			end
			ST_READ_ADDR: begin
				if (ar_hs)
					state_nxt = ST_READ_DATA;
			end
			ST_READ_DATA: begin
				if (r_hs)
					state_nxt = ST_IDLE;
			end
			ST_WRITE: begin
				if (aw_ok && w_ok) // both channels done, in any order
					state_nxt = ST_WRITE_RESP;
			end
			ST_WRITE_RESP: begin
				if (b_hs)
					state_nxt = ST_IDLE;
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge axi_aclk_i) begin
		if (!axi_aresetn_i) begin
			state_r      <= ST_IDLE;
			op_r         <= OP_NONE;
			aw_done_r    <= 1'b0;
			w_done_r     <= 1'b0;
			store_done_r <= 1'b0;
			err_r        <= 1'b0;
		end else begin
			state_r      <= state_nxt;
			store_done_r <= b_hs;
			err_r        <= (accept && !aligned)
			                || (r_hs && resp_err(axi_rresp_i))
			                || (b_hs && resp_err(axi_bresp_i));
			if (accept) begin
				op_r      <= req_op_i;
				aw_done_r <= 1'b0;
				w_done_r  <= 1'b0;
			end else begin
				if (aw_hs)
					aw_done_r <= 1'b1;
				if (w_hs)
					w_done_r <= 1'b1;
			end
		end
	end

	// request payload
	always_ff @(posedge axi_aclk_i) begin
		if (accept) begin
			addr_r <= req_addr_i;
			data_r <= req_wdata_i;
		end
	end

	assign axi_araddr_o = addr_r;
	assign axi_awaddr_o = addr_r;
	assign op_o         = op_r;
	assign offset_o     = addr_r[1:0];
	assign store_data_o = data_r;
	assign capture_o    = r_hs && !resp_err(axi_rresp_i); // no load result on error
	assign store_done_o = store_done_r;
	assign err_o        = err_r;

endmodule

`default_nettype wire

// ==== verilog/store_lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_lane_align (
	input  wire mem_access_pkg::mem_op_t              op_i,
	input  wire [1:0]                                 offset_i,
	input  wire [mem_access_pkg::AXI_DATA_W-1:0]      store_data_i,

	output logic [mem_access_pkg::AXI_DATA_W-1:0]     axi_wdata_o,
	output logic [mem_access_pkg::AXI_STRB_W-1:0]     axi_wstrb_o
);
	import mem_access_pkg::*;

	mem_word_u src;
	mem_word_u lanes;

	always_comb begin
		src = store_data_i;
		case (op_i)
			OP_SB: begin
				lanes.bytes = {AXI_STRB_W{src.bytes[0]}}; // low byte on every lane
				axi_wstrb_o = 4'b0001 << offset_i;
			end
			OP_SH: begin
				lanes.halves = {(AXI_DATA_W/16){src.halves[0]}};
				axi_wstrb_o  = 4'b0011 << {offset_i[1], 1'b0};
			end
			OP_SW: begin
				lanes       = src;
				axi_wstrb_o = 4'b1111;
			end
			default: begin
				lanes       = src;
				axi_wstrb_o = '0; // loads never write
			end
		endcase
	end

	assign axi_wdata_o = lanes;

endmodule

`default_nettype wire

// ==== verilog/load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extract (
	input  wire                                       axi_aclk_i,
	input  wire                                       axi_aresetn_i,
	input  wire                                       capture_i,
	input  wire mem_access_pkg::mem_op_t              op_i,
	input  wire [1:0]                                 offset_i,
	input  wire [mem_access_pkg::AXI_DATA_W-1:0]      axi_rdata_i,

	output logic [mem_access_pkg::AXI_DATA_W-1:0]     load_data_o,
	output logic                                      load_valid_o
);
	import mem_access_pkg::*;

	mem_word_u             word;
	logic [7:0]            sel_byte;
	logic [15:0]           sel_half;
	logic [AXI_DATA_W-1:0] ext;
	logic [AXI_DATA_W-1:0] data_r;
	logic                  valid_r;

	always_comb begin
		word     = axi_rdata_i;
		sel_byte = word.bytes[offset_i];
		sel_half = word.halves[offset_i[1]]; // bit 0 is zero for aligned halfwords
		case (op_i)
			OP_LB:   ext = {{(AXI_DATA_W-8){sel_byte[7]}}, sel_byte};
			OP_LBU:  ext = {{(AXI_DATA_W-8){1'b0}}, sel_byte};
			OP_LH:   ext = {{(AXI_DATA_W-16){sel_half[15]}}, sel_half};
			OP_LHU:  ext = {{(AXI_DATA_W-16){1'b0}}, sel_half};
			OP_LW:   ext = word;
			default: ext = '0;
		endcase
	end

	// result register, holds until the next load
	always_ff @(posedge axi_aclk_i) begin
		if (capture_i)
			data_r <= ext;
	end

	always_ff @(posedge axi_aclk_i) begin
		if (!axi_aresetn_i)
			valid_r <= 1'b0;
		else
			valid_r <= capture_i; // one cycle pulse
	end

	assign load_data_o  = data_r;
	assign load_valid_o = valid_r;

endmodule

`default_nettype wire

// ==== verilog/mem_axi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_axi_master (
	input  wire                                       axi_aclk_i,
	input  wire                                       axi_aresetn_i,

	// core side
	input  wire                                       req_start_i,
	input  wire mem_access_pkg::mem_op_t              req_op_i,
	input  wire [mem_access_pkg::AXI_ADDR_W-1:0]      req_addr_i,
	input  wire [mem_access_pkg::AXI_DATA_W-1:0]      req_wdata_i,
	output logic                                      busy_o,
	output logic                                      load_valid_o,
	output logic [mem_access_pkg::AXI_DATA_W-1:0]     load_data_o,
	output logic                                      store_done_o,
	output logic                                      err_o,

	// read channels
	output logic [mem_access_pkg::AXI_ADDR_W-1:0]     axi_araddr_o,
	output logic                                      axi_arvalid_o,
	input  wire                                       axi_arready_i,
	input  wire [mem_access_pkg::AXI_DATA_W-1:0]      axi_rdata_i,
	input  wire [1:0]                                 axi_rresp_i,
	input  wire                                       axi_rvalid_i,
	output logic                                      axi_rready_o,

	// write channels
	output logic [mem_access_pkg::AXI_ADDR_W-1:0]     axi_awaddr_o,
	output logic                                      axi_awvalid_o,
	input  wire                                       axi_awready_i,
	output logic [mem_access_pkg::AXI_DATA_W-1:0]     axi_wdata_o,
	output logic [mem_access_pkg::AXI_STRB_W-1:0]     axi_wstrb_o,
	output logic                                      axi_wvalid_o,
	input  wire                                       axi_wready_i,
	input  wire [1:0]                                 axi_bresp_i,
	input  wire                                       axi_bvalid_i,
	output logic                                      axi_bready_o
);
	import mem_access_pkg::*;

	mem_op_t               op_w;
	logic [1:0]            offset_w;
	logic [AXI_DATA_W-1:0] store_data_w;
	logic                  capture_w;

	mem_access_ctrl i_ctrl (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.req_start_i   (req_start_i),
		.req_op_i      (req_op_i),
		.req_addr_i    (req_addr_i),
		.req_wdata_i   (req_wdata_i),
		.axi_araddr_o  (axi_araddr_o),
		.axi_arvalid_o (axi_arvalid_o),
		.axi_arready_i (axi_arready_i),
		.axi_rvalid_i  (axi_rvalid_i),
		.axi_rresp_i   (axi_rresp_i),
		.axi_rready_o  (axi_rready_o),
		.axi_awaddr_o  (axi_awaddr_o),
		.axi_awvalid_o (axi_awvalid_o),
		.axi_awready_i (axi_awready_i),
		.axi_wvalid_o  (axi_wvalid_o),
		.axi_wready_i  (axi_wready_i),
		.axi_bvalid_i  (axi_bvalid_i),
		.axi_bresp_i   (axi_bresp_i),
		.axi_bready_o  (axi_bready_o),
		.op_o          (op_w),
		.offset_o      (offset_w),
		.store_data_o  (store_data_w),
		.capture_o     (capture_w),
		.busy_o        (busy_o),
		.store_done_o  (store_done_o),
		.err_o         (err_o)
	);

	store_lane_align i_store_align (
		.op_i         (op_w),
		.offset_i     (offset_w),
		.store_data_i (store_data_w),
		.axi_wdata_o  (axi_wdata_o),
		.axi_wstrb_o  (axi_wstrb_o)
	);

	load_extract i_load_extract (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.capture_i     (capture_w),
		.op_i          (op_w),
		.offset_i      (offset_w),
		.axi_rdata_i   (axi_rdata_i),
		.load_data_o   (load_data_o),
		.load_valid_o  (load_valid_o)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rstn_o
);
	initial begin
		clk_o  = 1'b0;
		rstn_o = 1'b0;
		repeat (4) @(posedge clk_o);
		#1 rstn_o = 1'b1; // released just after the 4th edge
	end

	always #5 clk_o = ~clk_o; // 10 ns period

endmodule

`default_nettype wire

// ==== testbench/mem_axi_master_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_axi_master_props (
	input wire        axi_aclk_i,
	input wire        axi_aresetn_i,
	input wire        req_start_i,
	input wire        busy_o, load_valid_o, store_done_o, err_o,
	input wire [31:0] axi_araddr_o, axi_awaddr_o, axi_wdata_o,
	input wire [3:0]  axi_wstrb_o,
	input wire [1:0]  axi_rresp_i, axi_bresp_i,
	input wire        axi_arvalid_o, axi_arready_i, axi_rvalid_i, axi_rready_o,
	input wire        axi_awvalid_o, axi_awready_i, axi_wvalid_o, axi_wready_i,
	input wire        axi_bvalid_i, axi_bready_o
);
	import mem_access_pkg::*;

	int unsigned fail_cnt = 0;

	task automatic note_failure(input string what);
		fail_cnt++;
		$error("FAILED at %0t: %s", $time, what);
	endtask

	quiet_after_reset: assert property (@(posedge axi_aclk_i) !axi_aresetn_i |=>
		!(axi_arvalid_o || axi_awvalid_o || axi_wvalid_o || axi_rready_o || axi_bready_o
		|| busy_o || load_valid_o || store_done_o || err_o))
		else note_failure("outputs active right after reset");

	ar_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o))
		else note_failure("AR dropped or moved before arready");
	aw_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o))
		else note_failure("AW dropped or moved before awready");
	w_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		axi_wvalid_o && !axi_wready_i |=> axi_wvalid_o && $stable({axi_wdata_o, axi_wstrb_o}))
		else note_failure("W dropped or moved before wready");

	// load result or error exactly one cycle after R
	r_done: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		axi_rvalid_i && axi_rready_o |=> !busy_o && (err_o != load_valid_o)
		&& (load_valid_o == ($past(axi_rresp_i) == RESP_OKAY)))
		else note_failure("load completion not one cycle after R handshake");
	b_done: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		axi_bvalid_i && axi_bready_o |=> !busy_o && store_done_o
		&& (err_o == ($past(axi_bresp_i) != RESP_OKAY)))
		else note_failure("store completion not one cycle after B handshake");

	// accepted request either starts or is refused, never both
	accept_split: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		req_start_i && !busy_o |=> busy_o != err_o)
		else note_failure("accepted request neither started nor refused");
	idle_quiet: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		!busy_o |-> !(axi_arvalid_o || axi_awvalid_o || axi_wvalid_o))
		else note_failure("bus valid raised while not busy");
	busy_start: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
		req_start_i && busy_o |=> $stable(axi_araddr_o) && $stable(axi_awaddr_o))
		else note_failure("start strobe while busy changed the request");

endmodule

`default_nettype wire

// ==== testbench/tb_mem_axi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_axi_master;
	import mem_access_pkg::*;

	localparam logic [31:0] ERR_BASE = 32'hF000_0000;

	logic        axi_aclk_i, axi_aresetn_i, req_start_i;
	mem_op_t     req_op_i;
	logic [31:0] req_addr_i, req_wdata_i, load_data_o, axi_rdata_i;
	logic [31:0] axi_araddr_o, axi_awaddr_o, axi_wdata_o;
	logic [3:0]  axi_wstrb_o;
	logic [1:0]  axi_rresp_i, axi_bresp_i;
	logic        busy_o, load_valid_o, store_done_o, err_o;
	logic        axi_arvalid_o, axi_arready_i, axi_rvalid_i, axi_rready_o;
	logic        axi_awvalid_o, axi_awready_i, axi_wvalid_o, axi_wready_i;
	logic        axi_bvalid_i, axi_bready_o;

	integer      seed = 32'h969a_a6c7;
	int          n_err = 0;
	mem_op_t     cur_op;
	logic [31:0] cur_addr, cur_wdata;
	logic [31:0] mem [logic [29:0]]; // written words, by word address
	mem_op_t     q_op[$];
	logic [31:0] q_addr[$], q_data[$];
	mem_op_t     load_ops[5] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
	mem_op_t     store_ops[3] = '{OP_SB, OP_SH, OP_SW};

	tb_clock_gen i_clk (.clk_o(axi_aclk_i), .rstn_o(axi_aresetn_i));
	mem_axi_master i_dut (.*);
	bind mem_axi_master mem_axi_master_props i_props (.*);

	function automatic logic [31:0] read_model(input logic [31:0] a);
		logic [31:0] w;
		w = ~{a[31:2], 2'b00};
		if (mem.exists(a[31:2]))
			return mem[a[31:2]];
		return {w[23:0], w[31:24]}; // inverted, rotated by 8
	endfunction

	function automatic logic [31:0] expect_load(input mem_op_t op, input logic [31:0] a,
			input logic [31:0] w);
		logic [31:0] s;
		s = w >> (8 * a[1:0]);
		case (op)
			OP_LB:   return {{24{s[7]}}, s[7:0]};
			OP_LBU:  return {24'h0, s[7:0]};
			OP_LH:   return {{16{s[15]}}, s[15:0]};
			OP_LHU:  return {16'h0, s[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic bit refused(input mem_op_t op, input logic [31:0] a);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 1'b0;
			OP_LH, OP_LHU, OP_SH: return a[0];
			OP_LW, OP_SW:         return a[1:0] != 2'b00;
			default:              return 1'b1;
		endcase
	endfunction

	function automatic int ready_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	task automatic report_mismatch(input string msg);
		n_err++;
		$display("FAILED at %0t: %s", $time, msg);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge axi_aclk_i);
			#1;
		end
	endtask

	task automatic serve_read();
		logic [31:0] a;
		forever begin
			@(posedge axi_aclk_i);
			if (axi_arvalid_o === 1'b1) begin
				#1 idle_cycles(ready_delay());
				axi_arready_i = 1'b1;
				@(posedge axi_aclk_i);
				a = axi_araddr_o;
				#1 axi_arready_i = 1'b0;
				assert (a == cur_addr)
					else report_mismatch($sformatf("araddr %h, expected %h", a, cur_addr));
				idle_cycles(ready_delay());
				axi_rvalid_i = 1'b1;
				axi_rdata_i  = read_model(a);
				axi_rresp_i  = (a >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
				do @(posedge axi_aclk_i); while (axi_rready_o !== 1'b1);
				#1 axi_rvalid_i = 1'b0;
			end
		end
	endtask

	task automatic serve_write();
		int d_aw, d_w;
		logic [31:0] a, w, m;
		logic [3:0] st;
		forever begin
			@(posedge axi_aclk_i);
			if (axi_awvalid_o === 1'b1 && axi_wvalid_o === 1'b1) begin
				d_aw = ready_delay();
				d_w  = ready_delay();
				#1;
				fork
					begin
						idle_cycles(d_aw);
						axi_awready_i = 1'b1;
						@(posedge axi_aclk_i);
						a = axi_awaddr_o;
						#1 axi_awready_i = 1'b0;
					end
					begin
						idle_cycles(d_w);
						axi_wready_i = 1'b1;
						@(posedge axi_aclk_i);
						w  = axi_wdata_o;
						st = axi_wstrb_o;
						#1 axi_wready_i = 1'b0;
					end
				join
				m = {{8{st[3]}}, {8{st[2]}}, {8{st[1]}}, {8{st[0]}}};
				assert (a == cur_addr)
					else report_mismatch($sformatf("awaddr %h, expected %h", a, cur_addr));
				assert (st == ((cur_op == OP_SW) ? 4'hf : ((cur_op == OP_SH) ? 4'h3 : 4'h1)
					<< cur_addr[1:0])) else report_mismatch($sformatf("wstrb %b", st));
				assert ((w & m) == ((cur_wdata << (8 * cur_addr[1:0])) & m))
					else report_mismatch($sformatf("wdata %h, strb %b", w, st));
				idle_cycles(ready_delay());
				axi_bvalid_i = 1'b1;
				axi_bresp_i  = (a >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
				if (a < ERR_BASE)
					mem[a[31:2]] = (read_model(a) & ~m) | (w & m);
				do @(posedge axi_aclk_i); while (axi_bready_o !== 1'b1);
				#1 axi_bvalid_i = 1'b0;
			end
		end
	endtask

	task automatic add_request(input mem_op_t op, input logic [31:0] a);
		q_op.push_back(op);
		q_addr.push_back(a);
		q_data.push_back($random(seed));
	endtask

	task automatic do_request(input mem_op_t op, input logic [31:0] a, input logic [31:0] wd,
			input bit poke);
		logic [31:0] exp_word;
		bit bad;
		exp_word    = read_model(a);
		bad         = a >= ERR_BASE;
		cur_op      = op;
		cur_addr    = a;
		cur_wdata   = wd;
		req_start_i = 1'b1;
		req_op_i    = op;
		req_addr_i  = a;
		req_wdata_i = wd;
		@(posedge axi_aclk_i);
		#1 req_start_i = 1'b0;
		if (poke && !refused(op, a)) begin
			req_start_i = 1'b1; // unit is busy here
			req_op_i    = OP_SB;
			req_addr_i  = a ^ 32'h0000_0040;
			@(posedge axi_aclk_i);
			#1 req_start_i = 1'b0;
		end
		do @(posedge axi_aclk_i); while (!(load_valid_o || store_done_o || err_o));
		if (refused(op, a)) begin
			assert (err_o && !load_valid_o && !store_done_o)
				else report_mismatch($sformatf("op %0d at %h not refused", op, a));
		end else if (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) begin
			assert (load_valid_o == !bad && err_o == bad)
				else report_mismatch($sformatf("load at %h, err %b", a, err_o));
			if (!bad) begin
				assert (load_data_o == expect_load(op, a, exp_word))
					else report_mismatch($sformatf("op %0d at %h gave %h", op, a, load_data_o));
			end
		end else begin
			assert (store_done_o && err_o == bad)
				else report_mismatch($sformatf("store at %h, err %b", a, err_o));
		end
		#1;
	endtask

	initial begin
		req_start_i   = 1'b0;
		req_op_i      = OP_NONE;
		req_addr_i    = '0;
		req_wdata_i   = '0;
		axi_arready_i = 1'b0;
		axi_rvalid_i  = 1'b0;
		axi_rdata_i   = '0;
		axi_rresp_i   = RESP_OKAY;
		axi_awready_i = 1'b0;
		axi_wready_i  = 1'b0;
		axi_bvalid_i  = 1'b0;
		axi_bresp_i   = RESP_OKAY;
		for (int off = 0; off < 4; off++) begin
			foreach (load_ops[i]) add_request(load_ops[i], 32'h0000_1000 + off);
			foreach (store_ops[i]) add_request(store_ops[i], 32'h0000_2000 + off);
		end
		for (int off = 0; off < 4; off++)
			foreach (load_ops[i]) add_request(load_ops[i], 32'h0000_2000 + off); // read back
		add_request(OP_LW, 32'hF000_0010);
		add_request(OP_LBU, 32'hF000_0013);
		add_request(OP_SW, 32'hF000_0020);
		add_request(OP_SH, 32'hF000_0022);
		add_request(OP_NONE, 32'h0000_0100);
		add_request(mem_op_t'(4'd9), 32'h0000_0100);
		add_request(mem_op_t'(4'd15), 32'h0000_0104);
		fork
			begin
				#((q_op.size() * 20 + 4) * 10);
				$display("timeout: requests did not complete in time, run stopped");
				$display("STATUS: FAIL");
				$finish;
			end
			serve_read();
			serve_write();
		join_none
		wait (axi_aresetn_i === 1'b1);
		foreach (q_op[i]) do_request(q_op[i], q_addr[i], q_data[i], i % 2 == 1);
		repeat (2) @(posedge axi_aclk_i);
		$display("errors: %0d value checks, %0d assertions", n_err, i_dut.i_props.fail_cnt);
		if (n_err == 0 && i_dut.i_props.fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/mem_access_pkg.sv
verilog/mem_access_ctrl.sv
verilog/store_lane_align.sv
verilog/load_extract.sv
verilog/mem_axi_master.sv
testbench/tb_clock_gen.sv
testbench/mem_axi_master_props.sv
testbench/tb_mem_axi_master.sv
